// ==== rtl/io_pkg.sv ====
`default_nettype none

package io_pkg;

  // CPU bus widths
  localparam int io_addr_w = 16;
  localparam int io_data_w = 8;

  // Beeper/tape port, only address bit 0 is decoded
  localparam logic [io_data_w-1:0] port_fe_lo = 8'hFE;

  // Covox port loads all four channels at once
  localparam logic [io_data_w-1:0] port_covox_all = 8'hFB;

  // Soundrive channel ports A to D
  localparam logic [io_data_w-1:0] port_sd_a = 8'h0F;
  localparam logic [io_data_w-1:0] port_sd_b = 8'h1F;
  localparam logic [io_data_w-1:0] port_sd_c = 8'h4F;
  localparam logic [io_data_w-1:0] port_sd_d = 8'h5F;

  // Bit positions inside port #FE
  localparam int fe_tape_out_bit = 3;
  localparam int fe_beeper_bit   = 4;
  localparam int fe_tape_in_bit  = 6;

endpackage

`default_nettype wire

// ==== rtl/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

  // Width of each mixed output sample
  localparam int sample_w = 12;

  // Covox / Soundrive DAC channels
  localparam int covox_w  = 8;
  localparam int covox_ch = 4;

  // Channel weight x4
  localparam int covox_shift = 2;

  // Beeper bit adds this to both sides
  localparam int beeper_level = 256;

endpackage

`default_nettype wire

// ==== rtl/io_bus_if.sv ====
`default_nettype none

interface io_bus_if;
  import io_pkg::*;

  logic [io_data_w-1:0] port;
  logic [io_data_w-1:0] wdata;
  logic                 wr_stb;
  logic                 rd_act;
  logic                 dos;

  // Decoder side
  modport dec (
    output port,
    output wdata,
    output wr_stb,
    output rd_act,
    output dos
  );

  // Register block side
  modport regs (
    input port,
    input wdata,
    input wr_stb,
    input rd_act,
    input dos
  );

endinterface

`default_nettype wire

// ==== rtl/io_decode.sv ====
`default_nettype none

module io_decode (
  input  logic                         fclk,
  input  logic                         rst,
  input  logic [io_pkg::io_addr_w-1:0] addr,
  input  logic [io_pkg::io_data_w-1:0] din,
  input  logic                         iorq_n,
  input  logic                         rd_n,
  input  logic                         wr_n,
  input  logic                         dos,
  io_bus_if.dec                        bus
);
  import io_pkg::*;

  logic                 wr_req;
  logic                 rd_lvl;
  logic                 wr_seen;
  logic                 wr_stb_q;
  logic [io_data_w-1:0] wr_port;
  logic [io_data_w-1:0] wr_data;

  // Z80 I/O cycle levels
  assign wr_req = ~iorq_n & ~wr_n;
  assign rd_lvl = ~iorq_n & ~rd_n;

  // One strobe per write, rearmed once the write is seen gone
  always_ff @(posedge fclk) begin
    if (rst) begin
      wr_seen  <= 1'b0;
      wr_stb_q <= 1'b0;
    end else begin
      wr_seen  <= wr_req;
      wr_stb_q <= wr_req & ~wr_seen;
    end
  end

  // Port and data captured on the first sampled edge of the write
  always_ff @(posedge fclk) begin
    if (wr_req && !wr_seen) begin
      wr_port <= addr[io_data_w-1:0];
      wr_data <= din;
    end
  end

  // Reads see the live address, writes the captured one
  assign bus.port   = rd_lvl ? addr[io_data_w-1:0] : wr_port;
  assign bus.wdata  = wr_data;
  assign bus.wr_stb = wr_stb_q;
  assign bus.rd_act = rd_lvl;
  assign bus.dos    = dos;

  a_stb_single: assert property (
    @(posedge fclk) disable iff (rst)
    bus.wr_stb |=> !bus.wr_stb
  ) else $error("wr_stb held high for two cycles");

endmodule

`default_nettype wire

// ==== rtl/audio_regs.sv ====
`default_nettype none

module audio_regs (
  input  logic                         fclk,
  input  logic                         rst,
  io_bus_if.regs                       bus,
  input  logic                         tape_in,
  output logic [io_pkg::io_data_w-1:0] dout,
  output logic                         dout_en,
  output logic                         tape_out,
  output logic                         beeper,
  output logic [audio_pkg::covox_ch-1:0][audio_pkg::covox_w-1:0] covox
);
  import io_pkg::*;
  import audio_pkg::*;

  // Soundrive port per channel, A to D
  localparam logic [io_data_w-1:0] sd_port [covox_ch] = '{
    port_sd_a,
    port_sd_b,
    port_sd_c,
    port_sd_d
  };

  logic                                fe_hit;
  logic                                beeper_q;
  logic                                tape_out_q;
  logic [covox_ch-1:0][covox_w-1:0]    covox_q;
  logic [1:0]                          tape_sync;
  logic [io_data_w-1:0]                rd_word;

  // #FE answers on any even port
  assign fe_hit = bus.port[0] == port_fe_lo[0];

  // Only the beeper and tape bits of #FE are kept
  always_ff @(posedge fclk) begin
    if (rst) begin
      beeper_q   <= 1'b0;
      tape_out_q <= 1'b0;
    end else if (bus.wr_stb && fe_hit) begin
      beeper_q   <= bus.wdata[fe_beeper_bit];
      tape_out_q <= bus.wdata[fe_tape_out_bit];
    end
  end

  // DAC channels, locked out in DOS mode
  always_ff @(posedge fclk) begin
    if (rst) begin
      covox_q <= '0;
    end else if (bus.wr_stb && !bus.dos) begin
      for (int i = 0; i < covox_ch; i++) begin
        if (bus.port == port_covox_all || bus.port == sd_port[i]) begin
          covox_q[i] <= bus.wdata;
        end
      end
    end
  end

  // Tape input is asynchronous
  always_ff @(posedge fclk) begin
    tape_sync <= {tape_sync[0], tape_in};
  end

  always_comb begin
    rd_word                 = '1;
    rd_word[fe_tape_in_bit] = tape_sync[1];
  end

  // Idle bus reads as #FF
  assign dout_en = bus.rd_act & fe_hit;
  assign dout    = dout_en ? rd_word : '1;

  assign tape_out = tape_out_q;
  assign beeper   = beeper_q;
  assign covox    = covox_q;

  a_dos_lock: assert property (
    @(posedge fclk)
    $past(bus.dos) && !$past(rst) |-> $stable(covox_q)
  ) else $error("Covox register changed in DOS mode");

endmodule

`default_nettype wire

// ==== rtl/audio_mixer.sv ====
`default_nettype none

module audio_mixer #(
  parameter int SAMPLE_DIV = 8
) (
  input  logic                                                  fclk,
  input  logic                                                  rst,
  input  logic                                                  beeper,
  input  logic [audio_pkg::covox_ch-1:0][audio_pkg::covox_w-1:0] covox,
  output logic [audio_pkg::sample_w-1:0]                        sound_l,
  output logic [audio_pkg::sample_w-1:0]                        sound_r,
  output logic                                                  sample_valid
);
  import audio_pkg::*;

  localparam int cnt_w = $clog2(SAMPLE_DIV);
  // One spare bit so an overflow is visible
  localparam int sum_w = sample_w + 1;

  logic [cnt_w-1:0] div_cnt;
  logic             tick;
  logic [sum_w-1:0] mix_l;
  logic [sum_w-1:0] mix_r;

  // Two channels at x4 plus the beeper term
  function automatic logic [sum_w-1:0] mix_pair(
    input logic [covox_w-1:0] ch_a,
    input logic [covox_w-1:0] ch_b,
    input logic               bp
  );
    logic [sum_w-1:0] acc;
    acc = sum_w'(ch_a) << covox_shift;
    acc = acc + (sum_w'(ch_b) << covox_shift);
    if (bp) begin
      acc = acc + sum_w'(beeper_level);
    end
    return acc;
  endfunction

  // Sample rate enable
  assign tick = div_cnt == cnt_w'(SAMPLE_DIV - 1);

  always_ff @(posedge fclk) begin
    if (rst || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // A and B go left, C and D right
  assign mix_l = mix_pair(covox[0], covox[1], beeper);
  assign mix_r = mix_pair(covox[2], covox[3], beeper);

  always_ff @(posedge fclk) begin
    if (rst) begin
      sound_l      <= '0;
      sound_r      <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= tick;
      if (tick) begin
        sound_l <= mix_l[sample_w-1:0];
        sound_r <= mix_r[sample_w-1:0];
      end
    end
  end

  a_sum_range: assert property (
    @(posedge fclk) disable iff (rst)
    !mix_l[sample_w] && !mix_r[sample_w]
  ) else $error("mixer sum out of sample range");

endmodule

`default_nettype wire

// ==== rtl/audio_top.sv ====
`default_nettype none

module audio_top #(
  parameter int SAMPLE_DIV = 8
) (
  input  logic                           fclk,
  input  logic                           rst,
  input  logic [io_pkg::io_addr_w-1:0]   addr,
  input  logic [io_pkg::io_data_w-1:0]   din,
  input  logic                           iorq_n,
  input  logic                           rd_n,
  input  logic                           wr_n,
  input  logic                           dos,
  input  logic                           tape_in,
  output logic [io_pkg::io_data_w-1:0]   dout,
  output logic                           dout_en,
  output logic                           tape_out,
  output logic [audio_pkg::sample_w-1:0] sound_l,
  output logic [audio_pkg::sample_w-1:0] sound_r,
  output logic                           sample_valid
);
  import audio_pkg::*;

  logic                             beeper;
  logic [covox_ch-1:0][covox_w-1:0] covox;

  io_bus_if bus ();

  io_decode u_decode (
    .fclk   (fclk),
    .rst    (rst),
    .addr   (addr),
    .din    (din),
    .iorq_n (iorq_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .dos    (dos),
    .bus    (bus.dec)
  );

  audio_regs u_regs (
    .fclk     (fclk),
    .rst      (rst),
    .bus      (bus.regs),
    .tape_in  (tape_in),
    .dout     (dout),
    .dout_en  (dout_en),
    .tape_out (tape_out),
    .beeper   (beeper),
    .covox    (covox)
  );

  // Fixed rate sample output
  audio_mixer #(
    .SAMPLE_DIV (SAMPLE_DIV)
  ) u_mixer (
    .fclk         (fclk),
    .rst          (rst),
    .beeper       (beeper),
    .covox        (covox),
    .sound_l      (sound_l),
    .sound_r      (sound_r),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

// ==== bench/audio_tb.sv ====
`default_nettype none

module audio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // The tests need well under 1000 cycles
  localparam int max_cycles = 4000;
  localparam int n_random   = 20;
  localparam int sample_div = 8;

  logic        fclk = 1'b0;
  logic        rst;
  logic [15:0] addr;
  logic [7:0]  din;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        dos;
  logic        tape_in;
  logic [7:0]  dout;
  logic        dout_en;
  logic        tape_out;
  logic [11:0] sound_l;
  logic [11:0] sound_r;
  logic        sample_valid;

  // Model of port #FE and the four DAC channels
  logic       beeper_m;
  logic       tape_m;
  logic [7:0] covox_m [4];

  logic [11:0] exp_l;
  logic [11:0] exp_r;
  int          req_cnt = 0;
  int          done_cnt = 0;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;

  int          chan;
  logic [7:0]  val;
  logic [7:0]  rdata;
  logic        ren;
  logic [15:0] exp_cov;

  audio_top DUT (
    .fclk         (fclk),
    .rst          (rst),
    .addr         (addr),
    .din          (din),
    .iorq_n       (iorq_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .dos          (dos),
    .tape_in      (tape_in),
    .dout         (dout),
    .dout_en      (dout_en),
    .tape_out     (tape_out),
    .sound_l      (sound_l),
    .sound_r      (sound_r),
    .sample_valid (sample_valid)
  );

  always #50 fclk = ~fclk;

  always @(posedge fclk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Each channel weighs 4 and the beeper adds 256
  // A and B feed the left side and C and D the right
  function automatic logic [23:0] mix_ref(input logic bp, input logic [7:0] ch_a,
                                          input logic [7:0] ch_b, input logic [7:0] ch_c,
                                          input logic [7:0] ch_d);
    logic [11:0] bp_term;
    logic [11:0] left;
    logic [11:0] right;
    bp_term = bp ? 12'd256 : 12'd0;
    left    = {2'b00, ch_a, 2'b00} + {2'b00, ch_b, 2'b00} + bp_term;
    right   = {2'b00, ch_c, 2'b00} + {2'b00, ch_d, 2'b00} + bp_term;
    return {left, right};
  endfunction

  function automatic logic [7:0] sd_port(input int ch);
    logic [7:0] p;
    case (ch)
      0:       p = 8'h0F;
      1:       p = 8'h1F;
      2:       p = 8'h4F;
      default: p = 8'h5F;
    endcase
    return p;
  endfunction

  task automatic model_write(input logic [7:0] port, input logic [7:0] data);
    // Any even port is #FE
    if (!port[0]) begin
      beeper_m = data[4];
      tape_m   = data[3];
    end
    if (!dos) begin
      case (port)
        8'hFB: begin
          for (int i = 0; i < 4; i++) begin
            covox_m[i] = data;
          end
        end
        8'h0F:   covox_m[0] = data;
        8'h1F:   covox_m[1] = data;
        8'h4F:   covox_m[2] = data;
        8'h5F:   covox_m[3] = data;
        default: ;
      endcase
    end
  endtask

  task automatic io_write(input logic [15:0] a, input logic [7:0] data);
    @(negedge fclk);
    addr   = a;
    din    = data;
    iorq_n = 1'b0;
    wr_n   = 1'b0;
    repeat (3) @(negedge fclk);
    iorq_n = 1'b1;
    wr_n   = 1'b1;
  endtask

  task automatic io_read(input logic [15:0] a, output logic [7:0] data,
                         output logic en);
    @(negedge fclk);
    addr   = a;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    repeat (2) @(negedge fclk);
    data = dout;
    en   = dout_en;
    @(negedge fclk);
    iorq_n = 1'b1;
    rd_n   = 1'b1;
  endtask

  // Hands the expected pair to the compare process and waits for it
  task automatic sample_check();
    logic [23:0] ref_pair;
    ref_pair = mix_ref(beeper_m, covox_m[0], covox_m[1], covox_m[2], covox_m[3]);
    exp_l    = ref_pair[23:12];
    exp_r    = ref_pair[11:0];
    req_cnt++;
    wait (done_cnt == req_cnt);
  endtask

  // The first sample after a write may predate it and is skipped
  task automatic compare_samples();
    int seen;
    int gap;
    forever begin
      wait (done_cnt != req_cnt);
      seen = 0;
      gap  = 0;
      while (seen < 2) begin
        @(negedge fclk);
        if (seen == 1) begin
          gap++;
        end
        if (sample_valid) begin
          seen++;
        end
      end
      check_value("sample_valid period", 16'(gap), 16'(sample_div));
      check_value("sound_l", 16'(sound_l), 16'(exp_l));
      check_value("sound_r", 16'(sound_r), 16'(exp_r));
      done_cnt++;
    end
  endtask

  task automatic write_port(input logic [15:0] a, input logic [7:0] data);
    io_write(a, data);
    model_write(a[7:0], data);
    check_value("tape_out", 16'(tape_out), 16'(tape_m));
    sample_check();
  endtask

  task automatic fe_read_check(input logic lvl);
    logic [7:0] exp_rd;
    @(negedge fclk);
    tape_in = lvl;
    // Let the synchronizer catch up
    repeat (3) @(negedge fclk);
    io_read(16'h00FE, rdata, ren);
    exp_rd    = 8'hFF;
    exp_rd[6] = lvl;
    check_value("dout_en", 16'(ren), 16'd1);
    check_value("dout", 16'(rdata), 16'(exp_rd));
  endtask

  initial begin
    rst     = 1'b1;
    addr    = '0;
    din     = '0;
    iorq_n  = 1'b1;
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    dos     = 1'b0;
    tape_in = 1'b0;
    beeper_m = 1'b0;
    tape_m   = 1'b0;
    for (int i = 0; i < 4; i++) begin
      covox_m[i] = '0;
    end
    void'($urandom(32'ha810));

    fork
      compare_samples();
    join_none

    repeat (3) @(negedge fclk);
    rst = 1'b0;

    // After reset
    check_value("sound_l", 16'(sound_l), 16'd0);
    check_value("sound_r", 16'(sound_r), 16'd0);
    check_value("sample_valid", 16'(sample_valid), 16'd0);
    check_value("tape_out", 16'(tape_out), 16'd0);
    check_value("dout_en", 16'(dout_en), 16'd0);
    check_value("dout", 16'(dout), 16'h00FF);
    sample_check();

    // Beeper and tape out on several even ports
    write_port(16'h00FE, 8'h10);
    write_port(16'hA5FE, 8'h08);
    write_port(16'h3C7A, 8'h18);

    // Soundrive channels
    for (int i = 0; i < n_random; i++) begin
      chan = int'($urandom % 4);
      val  = 8'($urandom);
      write_port({8'($urandom), sd_port(chan)}, val);
    end

    // Covox loads all four channels
    for (int i = 0; i < 2; i++) begin
      val = 8'($urandom);
      write_port({8'($urandom), 8'hFB}, val);
      exp_cov = 16'({val, 3'b000}) + (beeper_m ? 16'd256 : 16'd0);
      check_value("sound_l", 16'(sound_l), exp_cov);
      check_value("sound_r", 16'(sound_r), exp_cov);
    end

    // DOS mode locks the DAC but not #FE
    @(negedge fclk);
    dos = 1'b1;
    write_port(16'h00FB, 8'($urandom));
    write_port(16'h340F, 8'($urandom));
    write_port(16'h005F, 8'($urandom));
    val = beeper_m ? 8'h08 : 8'h10;
    write_port(16'h00FE, val);
    @(negedge fclk);
    dos = 1'b0;
    write_port(16'h001F, 8'($urandom));

    // Port #FE read with both tape levels
    fe_read_check(1'b0);
    fe_read_check(1'b1);
    io_read(16'h00FB, rdata, ren);
    check_value("dout_en", 16'(ren), 16'd0);
    check_value("dout", 16'(rdata), 16'h00FF);
    io_read(16'h12FD, rdata, ren);
    check_value("dout_en", 16'(ren), 16'd0);
    check_value("dout", 16'(rdata), 16'h00FF);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/io_pkg.sv
rtl/audio_pkg.sv
rtl/io_bus_if.sv
rtl/io_decode.sv
rtl/audio_regs.sv
rtl/audio_mixer.sv
rtl/audio_top.sv
bench/audio_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the audio testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f flist.f --top-module audio_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vaudio_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi

echo "Pass message not found"
exit 1
